//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_cpu_exec
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- cpu_alu.sv
`default_nettype none

`include "cpu_defines.svh"

module cpu_alu (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   cen,
    input  wire [`CPU_DW-1:0]     op0,
    input  wire [`CPU_DW-1:0]     op1,
    input  wire [`CPU_DW-1:0]     imm,
    input  wire                   sel_imm,   // second operand from imm
    input  wire cpu_pkg::alu_op_e op,
    input  wire cpu_pkg::width_t  w,         // zero is a bubble
    input  wire [`CPU_RAW-1:0]    dst,
    output logic [`CPU_DW-1:0]    dout,
    output logic [7:0]            flags,
    output cpu_pkg::width_t       we_w,
    output logic [`CPU_RAW-1:0]   we_idx
);

    logic [`CPU_DW-1:0] op2, rslt;
    logic [7:0]         nx_flags;
    logic               cin;                // carry flag into adc, sbc
    logic               half, c8, c16, c32; // lane carries or borrows
    logic               r_sign, a_sign, b_sign;
    logic               r_zero, w_carry;

    assign op2 = sel_imm ? imm : op1;
    assign cin = flags[cpu_pkg::FLAG_C] &
                 (op == cpu_pkg::ALU_ADC || op == cpu_pkg::ALU_SBC);

    // result, chained per lane so carries at every width fall out
    always_comb begin
        half = 1'b0;
        c8   = 1'b0;
        c16  = 1'b0;
        c32  = 1'b0;
        rslt = dout;
        case (op)
            cpu_pkg::ALU_MOVE: rslt = imm;
            cpu_pkg::ALU_ADD, cpu_pkg::ALU_ADC: begin
                {half, rslt[3:0]} = {1'b0, op0[3:0]} + {1'b0, op2[3:0]} + {4'd0, cin};
                {c8, rslt[7:4]}   = {1'b0, op0[7:4]} + {1'b0, op2[7:4]} + {4'd0, half};
                {c16, rslt[15:8]} = {1'b0, op0[15:8]} + {1'b0, op2[15:8]} + {8'd0, c8};
                {c32, rslt[`CPU_DW-1:16]} = {1'b0, op0[`CPU_DW-1:16]}
                                          + {1'b0, op2[`CPU_DW-1:16]} + {16'd0, c16};
            end
            cpu_pkg::ALU_SUB, cpu_pkg::ALU_SBC: begin
                // msb of each lane is the borrow out
                {half, rslt[3:0]} = {1'b0, op0[3:0]} - {1'b0, op2[3:0]} - {4'd0, cin};
                {c8, rslt[7:4]}   = {1'b0, op0[7:4]} - {1'b0, op2[7:4]} - {4'd0, half};
                {c16, rslt[15:8]} = {1'b0, op0[15:8]} - {1'b0, op2[15:8]} - {8'd0, c8};
                {c32, rslt[`CPU_DW-1:16]} = {1'b0, op0[`CPU_DW-1:16]}
                                          - {1'b0, op2[`CPU_DW-1:16]} - {16'd0, c16};
            end
            cpu_pkg::ALU_AND: rslt = op0 & op2;
            cpu_pkg::ALU_OR:  rslt = op0 | op2;
            cpu_pkg::ALU_XOR: rslt = op0 ^ op2;
            default:          rslt = dout;
        endcase
    end

    // width selected views
    always_comb begin
        if (w[0]) begin
            r_sign  = rslt[7];
            a_sign  = op0[7];
            b_sign  = op2[7];
            r_zero  = rslt[7:0] == '0;
            w_carry = c8;
        end else if (w[1]) begin
            r_sign  = rslt[15];
            a_sign  = op0[15];
            b_sign  = op2[15];
            r_zero  = rslt[15:0] == '0;
            w_carry = c16;
        end else begin  // long
            r_sign  = rslt[`CPU_DW-1];
            a_sign  = op0[`CPU_DW-1];
            b_sign  = op2[`CPU_DW-1];
            r_zero  = rslt == '0;
            w_carry = c32;
        end
    end

    always_comb begin
        nx_flags = flags;   // move keeps them
        case (op)
            cpu_pkg::ALU_ADD, cpu_pkg::ALU_ADC: begin
                nx_flags[cpu_pkg::FLAG_S] = r_sign;
                nx_flags[cpu_pkg::FLAG_Z] = r_zero;
                nx_flags[cpu_pkg::FLAG_H] = half;
                // same signs in, other sign out
                nx_flags[cpu_pkg::FLAG_V] = a_sign == b_sign && r_sign != a_sign;
                nx_flags[cpu_pkg::FLAG_N] = 1'b0;
                nx_flags[cpu_pkg::FLAG_C] = w_carry;
            end
            cpu_pkg::ALU_SUB, cpu_pkg::ALU_SBC: begin
                nx_flags[cpu_pkg::FLAG_S] = r_sign;
                nx_flags[cpu_pkg::FLAG_Z] = r_zero;
                nx_flags[cpu_pkg::FLAG_H] = half;     // borrow from bit 4
                nx_flags[cpu_pkg::FLAG_V] = a_sign != b_sign && r_sign != a_sign;
                nx_flags[cpu_pkg::FLAG_N] = 1'b1;
                nx_flags[cpu_pkg::FLAG_C] = w_carry;  // borrow at width
            end
            cpu_pkg::ALU_AND, cpu_pkg::ALU_OR, cpu_pkg::ALU_XOR: begin
                nx_flags[cpu_pkg::FLAG_S] = r_sign;
                nx_flags[cpu_pkg::FLAG_Z] = r_zero;
                nx_flags[cpu_pkg::FLAG_H] = op == cpu_pkg::ALU_AND;
                nx_flags[cpu_pkg::FLAG_V] = 1'b0;
                nx_flags[cpu_pkg::FLAG_N] = 1'b0;
                nx_flags[cpu_pkg::FLAG_C] = 1'b0;
            end
            default: nx_flags = flags;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dout   <= '0;
            flags  <= '0;
            we_w   <= cpu_pkg::W_NONE;
            we_idx <= '0;
        end else if (cen) begin
            if (w != cpu_pkg::W_NONE) begin   // bubble holds result and flags
                dout  <= rslt;
                flags <= nx_flags;
            end
            we_w   <= w;
            we_idx <= dst;
        end
    end

endmodule

`default_nettype wire

//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath width in bits
`define CPU_DW    32

// register bank size
`define CPU_NREGS 8

// register index width, log2 of CPU_NREGS
`define CPU_RAW   3

`endif

//--- cpu_exec.sv
`default_nettype none

`include "cpu_defines.svh"

module cpu_exec (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   cen,
    input  wire cpu_pkg::alu_op_e op,
    input  wire cpu_pkg::width_t  w,
    input  wire [`CPU_RAW-1:0]    rs0,
    input  wire [`CPU_RAW-1:0]    rs1,
    input  wire [`CPU_RAW-1:0]    rd,
    input  wire [`CPU_DW-1:0]     imm,
    input  wire                   sel_imm,
    output wire [`CPU_DW-1:0]     dout,
    output wire [7:0]             flags,
    output wire cpu_pkg::width_t  we      // width written back, zero for none
);

    // bank read side
    wire [`CPU_DW-1:0]     rd0, rd1;

    // operand stage towards the alu
    wire [`CPU_DW-1:0]     iss_op0, iss_op1, iss_imm;
    wire                   iss_sel_imm;
    wire cpu_pkg::alu_op_e iss_op;
    wire cpu_pkg::width_t  iss_w;
    wire [`CPU_RAW-1:0]    iss_dst;

    // alu result, write port and forwarding source
    wire [`CPU_RAW-1:0]    we_idx;

    cpu_regs i_regs (
        .clk    (clk),
        .reset  (reset),
        .cen    (cen),
        .rs0    (rs0),
        .rs1    (rs1),
        .rd0    (rd0),
        .rd1    (rd1),
        .we_w   (we),
        .we_idx (we_idx),
        .wdata  (dout)
    );

    cpu_issue i_issue (
        .clk        (clk),
        .reset      (reset),
        .cen        (cen),
        .op_in      (op),
        .w_in       (w),
        .rs0        (rs0),
        .rs1        (rs1),
        .rd         (rd),
        .imm_in     (imm),
        .sel_imm_in (sel_imm),
        .rd0        (rd0),
        .rd1        (rd1),
        .alu_dout   (dout),
        .alu_w      (we),
        .alu_idx    (we_idx),
        .op0        (iss_op0),
        .op1        (iss_op1),
        .imm        (iss_imm),
        .sel_imm    (iss_sel_imm),
        .op         (iss_op),
        .w          (iss_w),
        .dst        (iss_dst)
    );

    cpu_alu i_alu (
        .clk     (clk),
        .reset   (reset),
        .cen     (cen),
        .op0     (iss_op0),
        .op1     (iss_op1),
        .imm     (iss_imm),
        .sel_imm (iss_sel_imm),
        .op      (iss_op),
        .w       (iss_w),
        .dst     (iss_dst),
        .dout    (dout),
        .flags   (flags),
        .we_w    (we),
        .we_idx  (we_idx)
    );

endmodule

`default_nettype wire

//--- cpu_issue.sv
`default_nettype none

`include "cpu_defines.svh"

module cpu_issue (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     cen,
    // instruction fields
    input  wire cpu_pkg::alu_op_e   op_in,
    input  wire cpu_pkg::width_t    w_in,
    input  wire [`CPU_RAW-1:0]      rs0,
    input  wire [`CPU_RAW-1:0]      rs1,
    input  wire [`CPU_RAW-1:0]      rd,        // destination index
    input  wire [`CPU_DW-1:0]       imm_in,
    input  wire                     sel_imm_in,
    // operands from the bank
    input  wire [`CPU_DW-1:0]       rd0,
    input  wire [`CPU_DW-1:0]       rd1,
    // alu result not yet in the bank
    input  wire [`CPU_DW-1:0]       alu_dout,
    input  wire cpu_pkg::width_t    alu_w,
    input  wire [`CPU_RAW-1:0]      alu_idx,
    // held instruction towards the alu
    output logic [`CPU_DW-1:0]      op0,
    output logic [`CPU_DW-1:0]      op1,
    output logic [`CPU_DW-1:0]      imm,
    output logic                    sel_imm,
    output cpu_pkg::alu_op_e        op,
    output cpu_pkg::width_t         w,
    output logic [`CPU_RAW-1:0]     dst
);

    logic [`CPU_DW-1:0]  raw0, raw1;    // operands as read from the bank
    logic                fwd0, fwd1;    // source hit the previous dst

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            op      <= cpu_pkg::ALU_MOVE;
            w       <= cpu_pkg::W_NONE;   // start with a bubble
            dst     <= '0;
            sel_imm <= 1'b0;
            fwd0    <= 1'b0;
            fwd1    <= 1'b0;
        end else if (cen) begin
            op      <= op_in;
            w       <= w_in;
            dst     <= rd;
            sel_imm <= sel_imm_in;
            // held instruction moves into the alu on this same edge
            fwd0    <= rs0 == dst && w != cpu_pkg::W_NONE;
            fwd1    <= rs1 == dst && w != cpu_pkg::W_NONE;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (cen) begin
            raw0 <= rd0;
            raw1 <= rd1;
            imm  <= imm_in;
        end
    end

    // merge the in-flight result over the stale bank value
    always_comb begin
        op0 = raw0;
        op1 = raw1;
        if (fwd0) begin
            op0 = cpu_pkg::width_merge(raw0, alu_dout, alu_w);
        end
        if (fwd1) begin
            op1 = cpu_pkg::width_merge(raw1, alu_dout, alu_w);
        end
    end

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    // alu operation select
    typedef enum logic [3:0] {
        ALU_MOVE = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_ADC  = 4'd2,  // add with carry flag
        ALU_SUB  = 4'd3,
        ALU_SBC  = 4'd4,  // subtract with carry flag as borrow
        ALU_AND  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7
    } alu_op_e;

    // one-hot operand width: bit 0 byte, bit 1 word, bit 2 long
    typedef logic [2:0] width_t;

    localparam width_t W_NONE = 3'b000;  // bubble, nothing written

    // bit positions in the flags byte, {S,Z,0,H,0,V,N,C}
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    // bits of a register covered by a write of width w
    function automatic logic [`CPU_DW-1:0] width_mask(input width_t w);
        logic [`CPU_DW-1:0] m;
        m       = {`CPU_DW{w[2]}};    // long covers everything
        m[15:0] = {16{w[2] | w[1]}};  // word and up
        m[7:0]  = {8{|w}};            // any width touches the low byte
        return m;
    endfunction

    // new value over old value, only in the lanes the width covers
    function automatic logic [`CPU_DW-1:0] width_merge(
        input logic [`CPU_DW-1:0] old_v,
        input logic [`CPU_DW-1:0] new_v,
        input width_t             w
    );
        logic [`CPU_DW-1:0] m;
        m = width_mask(w);
        return (new_v & m) | (old_v & ~m);
    endfunction

endpackage

`default_nettype wire

//--- cpu_regs.sv
`default_nettype none

`include "cpu_defines.svh"

module cpu_regs (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  cen,
    input  wire [`CPU_RAW-1:0]   rs0,     // read port 0 index
    input  wire [`CPU_RAW-1:0]   rs1,     // read port 1 index
    output logic [`CPU_DW-1:0]   rd0,
    output logic [`CPU_DW-1:0]   rd1,
    input  wire cpu_pkg::width_t we_w,    // write width, zero means no write
    input  wire [`CPU_RAW-1:0]   we_idx,
    input  wire [`CPU_DW-1:0]    wdata
);

    logic [`CPU_DW-1:0] bank [`CPU_NREGS];
    logic               wr_active;
    logic [`CPU_DW-1:0] wr_merged;    // target register after the write

    assign wr_active = we_w != cpu_pkg::W_NONE;
    assign wr_merged = cpu_pkg::width_merge(bank[we_idx], wdata, we_w);

    // width-masked write, upper lanes keep their value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                bank[i] <= '0;
            end
        end else if (cen && wr_active) begin
            bank[we_idx] <= wr_merged;
        end
    end

    // read ports
    // a write pending on the same index shows through, so the operand
    // stage latches what the bank will hold after this edge
    always_comb begin
        rd0 = bank[rs0];
        rd1 = bank[rs1];
        if (wr_active && we_idx == rs0) begin
            rd0 = wr_merged;
        end
        if (wr_active && we_idx == rs1) begin
            rd1 = wr_merged;
        end
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
cpu_pkg.sv
cpu_regs.sv
cpu_issue.sv
cpu_alu.sv
cpu_exec.sv
tb_cpu_exec.sv

//--- tb_cpu_exec.sv
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu_exec;

    localparam int N_ARITH  = 200;
    localparam int N_LOGIC  = 100;
    localparam int N_HAZARD = 300;
    localparam int N_GAPPED = 300;
    localparam int MAX_GAP  = 3;    // longest run of cen-low cycles
    // reset reads, seeding, mask checks and drain around the random phases
    localparam int N_TOTAL  = 9 + 8 + N_ARITH + N_LOGIC + 24 + N_HAZARD + N_GAPPED + 3;
    localparam int TIMEOUT_CYCLES = N_TOTAL * (MAX_GAP + 1) + 50;

    typedef struct packed {
        cpu_pkg::width_t    we;
        logic [7:0]         flags;
        logic [`CPU_DW-1:0] dout;
    } expect_t;

    logic                clk;
    logic                reset;
    logic                cen;
    cpu_pkg::alu_op_e    op;
    cpu_pkg::width_t     w;
    logic [`CPU_RAW-1:0] rs0, rs1, rd;
    logic [`CPU_DW-1:0]  imm;
    logic                sel_imm;
    wire [`CPU_DW-1:0]   dout;
    wire [7:0]           flags;
    wire cpu_pkg::width_t we;

    logic [`CPU_DW-1:0]  m_regs [`CPU_NREGS];  // model register file
    logic [7:0]          m_flags;
    logic [`CPU_DW-1:0]  m_dout;               // last non-bubble result
    expect_t             exp_q [$];            // results still in flight
    expect_t             last_exp;             // what the outputs hold now
    logic                prev_cen;             // cen seen by the coming edge
    logic [`CPU_RAW-1:0] hist [2];             // last two destinations
    logic [31:0]         rng_state;
    int                  cycle_count = 0;

    cpu_exec i_dut (
        .clk     (clk),
        .reset   (reset),
        .cen     (cen),
        .op      (op),
        .w       (w),
        .rs0     (rs0),
        .rs1     (rs1),
        .rd      (rd),
        .imm     (imm),
        .sel_imm (sel_imm),
        .dout    (dout),
        .flags   (flags),
        .we      (we)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, run went past %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // lcg stepped twice for 32 bits from the better upper halves
    function automatic logic [31:0] next_random();
        logic [15:0] hi;
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        hi        = rng_state[31:16];
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return {hi, rng_state[31:16]};
    endfunction

    function automatic logic [`CPU_RAW-1:0] rand_reg();
        logic [31:0] r;
        r = next_random();
        return r[`CPU_RAW+7:8];
    endfunction

    function automatic cpu_pkg::width_t rand_width();
        logic [31:0]     r;
        cpu_pkg::width_t wr;
        r = next_random();
        case (r % 32'd3)
            32'd0:   wr = 3'b001;   // byte
            32'd1:   wr = 3'b010;   // word
            default: wr = 3'b100;   // long
        endcase
        return wr;
    endfunction

    // class 0 arithmetic, class 1 logic and move, anything else all ops
    function automatic cpu_pkg::alu_op_e rand_op(input int op_class);
        logic [31:0]      r;
        cpu_pkg::alu_op_e o;
        r = next_random();
        case (op_class == 2 ? r[2:0] : {op_class == 1, r[1:0]})
            3'd0:    o = cpu_pkg::ALU_ADD;
            3'd1:    o = cpu_pkg::ALU_ADC;
            3'd2:    o = cpu_pkg::ALU_SUB;
            3'd3:    o = cpu_pkg::ALU_SBC;
            3'd4:    o = cpu_pkg::ALU_AND;
            3'd5:    o = cpu_pkg::ALU_OR;
            3'd6:    o = cpu_pkg::ALU_XOR;
            default: o = cpu_pkg::ALU_MOVE;
        endcase
        return o;
    endfunction

    // source biased towards recent destinations
    function automatic logic [`CPU_RAW-1:0] pick_src();
        logic [31:0] r;
        r = next_random();
        case (r[1:0])
            2'd0, 2'd1: return hist[0];   // distance 1 via forwarding
            2'd2:       return hist[1];   // distance 2 via write-through
            default:    return r[`CPU_RAW+7:8];
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0t %s: got %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_outputs(input expect_t e);
        check_value("dout", dout, e.dout);
        check_value("flags", {24'd0, flags}, {24'd0, e.flags});
        check_value("we", {29'd0, we}, {29'd0, e.we});
    endtask

    // reference execution in program order at issue
    task automatic model_issue(input cpu_pkg::alu_op_e o, input cpu_pkg::width_t wi,
                               input logic [`CPU_RAW-1:0] s0, input logic [`CPU_RAW-1:0] s1,
                               input logic [`CPU_RAW-1:0] d, input logic [31:0] im,
                               input logic si);
        logic [31:0] a, b, res, m;
        logic [32:0] am, bm, ci;
        logic [4:0]  na, nb, nc;
        logic [7:0]  f;
        int          n;
        longint      sa, sb, sr, lim;
        expect_t     e;
        a  = m_regs[s0];
        b  = si ? im : m_regs[s1];
        n  = wi[0] ? 8 : (wi[1] ? 16 : 32);
        m  = (n == 32) ? 32'hffff_ffff : (32'd1 << n) - 32'd1;
        am = {1'b0, a & m};
        bm = {1'b0, b & m};
        ci = {32'd0, m_flags[cpu_pkg::FLAG_C] &
                     (o == cpu_pkg::ALU_ADC || o == cpu_pkg::ALU_SBC)};
        na = {1'b0, a[3:0]};
        nb = {1'b0, b[3:0]};
        nc = {4'd0, ci[0]};
        // two's complement values of the operands at width
        lim = longint'(1) << (n - 1);
        sa  = longint'(a & m) - (a[n-1] ? 2 * lim : 0);
        sb  = longint'(b & m) - (b[n-1] ? 2 * lim : 0);
        f   = m_flags;
        res = im;   // move keeps the flags
        case (o)
            cpu_pkg::ALU_ADD, cpu_pkg::ALU_ADC: begin
                res = a + b + ci[31:0];
                sr  = sa + sb + longint'(ci[0]);
                f[cpu_pkg::FLAG_C] = am + bm + ci > {1'b0, m};   // carry out at width
                f[cpu_pkg::FLAG_H] = na + nb + nc > 5'd15;
                f[cpu_pkg::FLAG_V] = sr >= lim || sr < -lim;     // signed sum does not fit
                f[cpu_pkg::FLAG_N] = 1'b0;
            end
            cpu_pkg::ALU_SUB, cpu_pkg::ALU_SBC: begin
                res = a - b - ci[31:0];
                sr  = sa - sb - longint'(ci[0]);
                f[cpu_pkg::FLAG_C] = am < bm + ci;   // borrow at width
                f[cpu_pkg::FLAG_H] = na < nb + nc;   // borrow from bit 4
                f[cpu_pkg::FLAG_V] = sr >= lim || sr < -lim;
                f[cpu_pkg::FLAG_N] = 1'b1;
            end
            cpu_pkg::ALU_AND, cpu_pkg::ALU_OR, cpu_pkg::ALU_XOR: begin
                if (o == cpu_pkg::ALU_AND) res = a & b;
                else if (o == cpu_pkg::ALU_OR) res = a | b;
                else res = a ^ b;
                f[cpu_pkg::FLAG_H] = o == cpu_pkg::ALU_AND;
                f[cpu_pkg::FLAG_V] = 1'b0;
                f[cpu_pkg::FLAG_N] = 1'b0;
                f[cpu_pkg::FLAG_C] = 1'b0;
            end
            default: ;
        endcase
        if (o != cpu_pkg::ALU_MOVE) begin
            f[cpu_pkg::FLAG_S] = res[n-1];
            f[cpu_pkg::FLAG_Z] = (res & m) == '0;
        end
        if (wi != cpu_pkg::W_NONE) begin   // bubble leaves everything alone
            m_dout    = res;
            m_flags   = f;
            m_regs[d] = (m_regs[d] & ~m) | (res & m);
        end
        e.we    = wi;
        e.flags = m_flags;
        e.dout  = m_dout;
        exp_q.push_back(e);
    endtask

    // check what the last edge produced, then drive the next cycle
    task automatic run_cycle(input logic c, input cpu_pkg::alu_op_e o, input cpu_pkg::width_t wi,
                             input logic [`CPU_RAW-1:0] s0, input logic [`CPU_RAW-1:0] s1,
                             input logic [`CPU_RAW-1:0] d, input logic [31:0] im,
                             input logic si);
        @(posedge clk);
        #1;
        if (prev_cen) begin
            if (exp_q.size() == 0) abort_run("expected-value queue ran empty");
            else last_exp = exp_q.pop_front();
        end
        check_outputs(last_exp);   // unchanged after a cen-low edge
        cen      = c;
        op       = o;
        w        = wi;
        rs0      = s0;
        rs1      = s1;
        rd       = d;
        imm      = im;
        sel_imm  = si;
        prev_cen = c;
        if (c) model_issue(o, wi, s0, s1, d, im, si);
    endtask

    task automatic random_instr(input int op_class, input bit hazard, input bit allow_bubble);
        logic [31:0]         r;
        cpu_pkg::width_t     wi;
        logic [`CPU_RAW-1:0] s0, s1, d;
        r  = next_random();
        wi = rand_width();
        if (allow_bubble && r[7:5] == 3'd0) wi = cpu_pkg::W_NONE;
        s0 = hazard ? pick_src() : rand_reg();
        s1 = hazard ? pick_src() : rand_reg();
        d  = rand_reg();
        run_cycle(1'b1, rand_op(op_class), wi, s0, s1, d, next_random(),
                  hazard ? r[3:2] == 2'b00 : r[0]);
        hist[1] = hist[0];
        hist[0] = d;
    endtask

    // random junk on the inputs while cen is low
    task automatic idle_cycle();
        run_cycle(1'b0, rand_op(2), rand_width(), rand_reg(), rand_reg(), rand_reg(),
                  next_random(), 1'b0);
    endtask

    initial begin
        logic [31:0] r;
        rng_state = 32'd6;
        reset     = 1'b1;
        cen       = 1'b0;
        op        = cpu_pkg::ALU_MOVE;
        w         = cpu_pkg::W_NONE;
        rs0       = '0;
        rs1       = '0;
        rd        = '0;
        imm       = '0;
        sel_imm   = 1'b0;
        prev_cen  = 1'b0;
        m_flags   = '0;
        m_dout    = '0;
        hist[0]   = '0;
        hist[1]   = '0;
        for (int i = 0; i < `CPU_NREGS; i++) m_regs[i] = '0;
        last_exp = '0;
        exp_q.push_back(last_exp);   // operand stage holds a bubble out of reset
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // reset values, then read every register back
        check_outputs(last_exp);
        run_cycle(1'b1, cpu_pkg::ALU_MOVE, 3'b100, 3'd0, 3'd0, 3'd7, next_random(), 1'b1);
        for (int i = 0; i < `CPU_NREGS; i++) begin
            run_cycle(1'b1, cpu_pkg::ALU_ADD, 3'b100, i[`CPU_RAW-1:0], 3'd0,
                      i[`CPU_RAW-1:0], 32'd0, 1'b1);
        end

        // seed long values, then arithmetic and logic mixes
        for (int i = 0; i < `CPU_NREGS; i++) begin
            run_cycle(1'b1, cpu_pkg::ALU_MOVE, 3'b100, 3'd0, 3'd0, i[`CPU_RAW-1:0],
                      next_random(), 1'b1);
        end
        repeat (N_ARITH) random_instr(0, 1'b0, 1'b0);
        repeat (N_LOGIC) random_instr(1, 1'b0, 1'b0);

        // long value, partial overwrite, long read
        for (int i = 0; i < `CPU_NREGS; i++) begin
            run_cycle(1'b1, cpu_pkg::ALU_MOVE, 3'b100, 3'd0, 3'd0, i[`CPU_RAW-1:0],
                      next_random(), 1'b1);
            run_cycle(1'b1, rand_op(2), i[0] ? 3'b010 : 3'b001, i[`CPU_RAW-1:0], 3'd0,
                      i[`CPU_RAW-1:0], next_random(), 1'b1);
            run_cycle(1'b1, cpu_pkg::ALU_ADD, 3'b100, i[`CPU_RAW-1:0], 3'd0,
                      i[`CPU_RAW-1:0], 32'd0, 1'b1);
        end

        // dense dependent stream
        repeat (N_HAZARD) random_instr(2, 1'b1, 1'b0);

        // same with cen gaps and bubbles
        repeat (N_GAPPED) begin
            r = next_random();
            if (r[31:30] == 2'b00) begin
                repeat (1 + int'(r % 32'd3)) idle_cycle();
            end
            random_instr(2, 1'b1, 1'b1);
        end

        // flush the last results out
        repeat (3) run_cycle(1'b1, cpu_pkg::ALU_MOVE, cpu_pkg::W_NONE, 3'd0, 3'd0, 3'd0,
                             32'd0, 1'b0);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
